// ==== hdl/vec_pkg.sv ====
/*
 * Shared widths, types and encodings for the vector pipeline slice.
 * RTL and bench files refer to these by scoped name.
 */
package vec_pkg;
	localparam int vector_lanes = 4;
	localparam int thread_count = 4;
	localparam int scalar_width = 32;

	typedef logic [scalar_width - 1:0] scalar_t;
	typedef logic [scalar_width * vector_lanes - 1:0] vector_t;
	typedef logic [vector_lanes - 1:0] mask_t;
	typedef logic [$clog2(thread_count) - 1:0] thread_idx_t;
	typedef logic [4:0] alu_op_t;
	typedef logic [2:0] branch_type_t;
	typedef logic [31:0] instruction_t;
	typedef logic [4:0] reg_idx_t;

	// ALU operations, codes 4, 7, 8, 27 and 31 are unused
	localparam alu_op_t op_or = 5'd0;
	localparam alu_op_t op_and = 5'd1;
	localparam alu_op_t op_uminus = 5'd2;
	localparam alu_op_t op_xor = 5'd3;
	localparam alu_op_t op_iadd = 5'd5;
	localparam alu_op_t op_isub = 5'd6;
	localparam alu_op_t op_asr = 5'd9;
	localparam alu_op_t op_lsr = 5'd10;
	localparam alu_op_t op_lsl = 5'd11;
	localparam alu_op_t op_clz = 5'd12;
	localparam alu_op_t op_shuffle = 5'd13;
	localparam alu_op_t op_ctz = 5'd14;
	localparam alu_op_t op_copy = 5'd15;
	// Compare family occupies one contiguous range
	localparam alu_op_t op_equal = 5'd16;
	localparam alu_op_t op_nequal = 5'd17;
	localparam alu_op_t op_sigtr = 5'd18;
	localparam alu_op_t op_sigte = 5'd19;
	localparam alu_op_t op_silt = 5'd20;
	localparam alu_op_t op_silte = 5'd21;
	localparam alu_op_t op_uigtr = 5'd22;
	localparam alu_op_t op_uigte = 5'd23;
	localparam alu_op_t op_uilt = 5'd24;
	localparam alu_op_t op_uilte = 5'd25;
	localparam alu_op_t op_getlane = 5'd26;
	localparam alu_op_t op_recip = 5'd28;
	localparam alu_op_t op_sext8 = 5'd29;
	localparam alu_op_t op_sext16 = 5'd30;

	// Branch conditions
	localparam branch_type_t branch_all = 3'd0;
	localparam branch_type_t branch_zero = 3'd1;
	localparam branch_type_t branch_not_zero = 3'd2;
	localparam branch_type_t branch_always = 3'd3;
	localparam branch_type_t branch_call_offset = 3'd4;
	localparam branch_type_t branch_not_all = 3'd5;
	localparam branch_type_t branch_call_register = 3'd6;

	// Instruction word layout
	localparam int alu_op_msb = 31;
	localparam int alu_op_lsb = 27;
	localparam int branch_type_msb = 26;
	localparam int branch_type_lsb = 24;
	localparam int is_branch_bit = 23;
	localparam int is_vector_bit = 22;
	localparam int has_dest_bit = 21;
	localparam int dest_msb = 20;
	localparam int dest_lsb = 16;
	localparam int imm_msb = 15;
	localparam int imm_lsb = 0;
endpackage

// ==== hdl/reciprocal_rom.sv ====
/*
 * Lookup table for the reciprocal estimate. The address is the top six
 * significand bits and the data is the top six bits of the reciprocal
 * significand, with the implied leading one dropped.
 */
`timescale 1ns/1ps

module reciprocal_rom(
	input logic [5:0] addr,
	output logic [5:0] data
);
	// Entry i holds floor(8192 / (64 + i)) - 64, entry 0 wraps to 0
	always_comb
	begin
		case (addr)
			6'd0: data = 6'd0;
			6'd1: data = 6'd62;
			6'd2: data = 6'd60;
			6'd3: data = 6'd58;
			6'd4: data = 6'd56;
			6'd5: data = 6'd54;
			6'd6: data = 6'd53;
			6'd7: data = 6'd51;
			6'd8: data = 6'd49;
			6'd9: data = 6'd48;
			6'd10: data = 6'd46;
			6'd11: data = 6'd45;
			6'd12: data = 6'd43;
			6'd13: data = 6'd42;
			6'd14: data = 6'd41;
			6'd15: data = 6'd39;
			6'd16: data = 6'd38;
			6'd17: data = 6'd37;
			6'd18: data = 6'd35;
			6'd19: data = 6'd34;
			6'd20: data = 6'd33;
			6'd21: data = 6'd32;
			6'd22: data = 6'd31;
			6'd23: data = 6'd30;
			6'd24: data = 6'd29;
			6'd25: data = 6'd28;
			6'd26: data = 6'd27;
			6'd27: data = 6'd26;
			6'd28: data = 6'd25;
			6'd29: data = 6'd24;
			6'd30: data = 6'd23;
			6'd31: data = 6'd22;
			6'd32: data = 6'd21;
			6'd33: data = 6'd20;
			6'd34: data = 6'd19;
			6'd35: data = 6'd18;
			6'd36: data = 6'd17;
			6'd37: data = 6'd17;
			6'd38: data = 6'd16;
			6'd39: data = 6'd15;
			6'd40: data = 6'd14;
			6'd41: data = 6'd14;
			6'd42: data = 6'd13;
			6'd43: data = 6'd12;
			6'd44: data = 6'd11;
			6'd45: data = 6'd11;
			6'd46: data = 6'd10;
			6'd47: data = 6'd9;
			6'd48: data = 6'd9;
			6'd49: data = 6'd8;
			6'd50: data = 6'd7;
			6'd51: data = 6'd7;
			6'd52: data = 6'd6;
			6'd53: data = 6'd6;
			6'd54: data = 6'd5;
			6'd55: data = 6'd4;
			6'd56: data = 6'd4;
			6'd57: data = 6'd3;
			6'd58: data = 6'd3;
			6'd59: data = 6'd2;
			6'd60: data = 6'd2;
			6'd61: data = 6'd1;
			6'd62: data = 6'd1;
			default: data = 6'd0;
		endcase
	end
endmodule

// ==== hdl/lane_alu.sv ====
/*
 * Single-cycle integer ALU for one lane. Execute holds one copy per lane
 * and picks the result by alu_op. Lane-select operations read the whole
 * first operand vector.
 */
`timescale 1ns/1ps

module lane_alu(
	input vec_pkg::alu_op_t alu_op,
	input vec_pkg::scalar_t operand1,
	input vec_pkg::scalar_t operand2,
	input logic [1:0] lane_index,
	input vec_pkg::vector_t vector_operand1,
	output vec_pkg::scalar_t result
);
	vec_pkg::scalar_t difference;
	logic borrow;
	logic negative;
	logic overflow;
	logic zero;
	logic signed_gtr;
	logic [5:0] lz;
	logic [5:0] tz;
	logic shift_fill;
	logic [63:0] rshift_wide;
	logic [1:0] select_lane;
	vec_pkg::scalar_t selected;
	logic [5:0] recip_table;
	logic [7:0] recip_exponent;
	vec_pkg::scalar_t reciprocal;

	// Compare flags all come from one subtraction
	assign {borrow, difference} = {1'b0, operand1} - {1'b0, operand2};
	assign negative = difference[31];
	assign overflow = operand2[31] == negative && operand1[31] != operand2[31];
	assign zero = difference == 0;
	assign signed_gtr = overflow == negative;

	// Highest set bit wins
	always_comb
	begin
		lz = 6'd32;
		for (int i = 0; i < 32; i++)
			if (operand2[i])
				lz = 6'(31 - i);
	end

	// Lowest set bit wins
	always_comb
	begin
		tz = 6'd32;
		for (int i = 31; i >= 0; i--)
			if (operand2[i])
				tz = 6'(i);
	end

	assign shift_fill = alu_op == vec_pkg::op_asr && operand1[31];
	assign rshift_wide = {{32{shift_fill}}, operand1} >> operand2[4:0];

	// Lane 0 sits in the low bits, so index 0 reads the top lane
	assign select_lane = 2'(vec_pkg::vector_lanes - 1) - operand2[1:0];
	assign selected = vector_operand1[select_lane * vec_pkg::scalar_width +: vec_pkg::scalar_width];

	reciprocal_rom rom(
		.addr(operand2[22:17]),
		.data(recip_table));

	assign recip_exponent = 8'd253 - operand2[30:23] + 8'(operand2[22:17] == 6'd0);

	always_comb
	begin
		if (operand2[30:23] == 8'd0)
			reciprocal = {operand2[31], 8'hff, 23'd0};
		else if (operand2[30:23] == 8'hff)
		begin
			// NaN in, NaN out; infinity in, signed zero out
			if (operand2[22:0] != 23'd0)
				reciprocal = {1'b0, 8'hff, 23'h7fffff};
			else
				reciprocal = {operand2[31], 8'h00, 23'd0};
		end
		else
			reciprocal = {operand2[31], recip_exponent, recip_table, 17'd0};
	end

	always_comb
	begin
		case (alu_op)
			vec_pkg::op_asr,
			vec_pkg::op_lsr: result = operand2[31:5] == 0 ? rshift_wide[31:0] : {32{shift_fill}};
			vec_pkg::op_lsl: result = operand2[31:5] == 0 ? operand1 << operand2[4:0] : 32'd0;
			vec_pkg::op_copy: result = operand2;
			vec_pkg::op_or: result = operand1 | operand2;
			vec_pkg::op_and: result = operand1 & operand2;
			vec_pkg::op_xor: result = operand1 ^ operand2;
			vec_pkg::op_iadd: result = operand1 + operand2;
			vec_pkg::op_isub: result = difference;
			vec_pkg::op_uminus: result = -operand2;
			vec_pkg::op_clz: result = {26'd0, lz};
			vec_pkg::op_ctz: result = {26'd0, tz};
			vec_pkg::op_equal: result = {31'd0, zero};
			vec_pkg::op_nequal: result = {31'd0, !zero};
			vec_pkg::op_sigtr: result = {31'd0, signed_gtr && !zero};
			vec_pkg::op_sigte: result = {31'd0, signed_gtr || zero};
			vec_pkg::op_silt: result = {31'd0, !signed_gtr && !zero};
			vec_pkg::op_silte: result = {31'd0, !signed_gtr || zero};
			vec_pkg::op_uigtr: result = {31'd0, !borrow && !zero};
			vec_pkg::op_uigte: result = {31'd0, !borrow || zero};
			vec_pkg::op_uilt: result = {31'd0, borrow && !zero};
			vec_pkg::op_uilte: result = {31'd0, borrow || zero};
			vec_pkg::op_sext8: result = {{24{operand2[7]}}, operand2[7:0]};
			vec_pkg::op_sext16: result = {{16{operand2[15]}}, operand2[15:0]};
			vec_pkg::op_getlane,
			vec_pkg::op_shuffle: result = selected;
			vec_pkg::op_recip: result = reciprocal;
			default: result = 32'd0;
		endcase
	end
endmodule

// ==== hdl/instruction_decoder.sv ====
/*
 * Decode stage. Splits the instruction word into its fields and registers
 * them together with pc, thread, operands and mask. An instruction whose
 * thread is being rolled back this cycle is dropped.
 */
`timescale 1ns/1ps

module instruction_decoder(
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input vec_pkg::instruction_t instr,
	input vec_pkg::scalar_t instr_pc,
	input vec_pkg::thread_idx_t instr_thread,
	input vec_pkg::vector_t operand1,
	input vec_pkg::vector_t operand2,
	input vec_pkg::mask_t mask,
	input logic rollback_en,
	input vec_pkg::thread_idx_t rollback_thread,
	output logic id_valid,
	output vec_pkg::alu_op_t id_alu_op,
	output vec_pkg::branch_type_t id_branch_type,
	output logic id_is_branch,
	output logic id_is_vector,
	output logic id_has_dest,
	output vec_pkg::reg_idx_t id_dest,
	output vec_pkg::scalar_t id_immediate,
	output vec_pkg::scalar_t id_pc,
	output vec_pkg::thread_idx_t id_thread,
	output vec_pkg::vector_t id_operand1,
	output vec_pkg::vector_t id_operand2,
	output vec_pkg::mask_t id_mask
);
	logic squash;

	assign squash = rollback_en && rollback_thread == instr_thread;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			id_valid <= 1'b0;
		else
			id_valid <= instr_valid && !squash;
	end

	always_ff @(posedge clk)
	begin
		id_alu_op <= instr[vec_pkg::alu_op_msb:vec_pkg::alu_op_lsb];
		id_branch_type <= instr[vec_pkg::branch_type_msb:vec_pkg::branch_type_lsb];
		id_is_branch <= instr[vec_pkg::is_branch_bit];
		id_is_vector <= instr[vec_pkg::is_vector_bit];
		id_has_dest <= instr[vec_pkg::has_dest_bit];
		id_dest <= instr[vec_pkg::dest_msb:vec_pkg::dest_lsb];
		// 16-bit immediate, sign extended to a full lane
		id_immediate <= {{16{instr[vec_pkg::imm_msb]}}, instr[vec_pkg::imm_msb:vec_pkg::imm_lsb]};
		id_pc <= instr_pc;
		id_thread <= instr_thread;
		id_operand1 <= operand1;
		id_operand2 <= operand2;
		id_mask <= mask;
	end

	// A rolled-back thread must not leak into execute
	squashed_input_dropped: assert property (@(posedge clk) disable iff (reset)
		instr_valid && squash |=> !id_valid);
endmodule

// ==== hdl/single_cycle_execute.sv ====
/*
 * Execute stage. Runs one ALU per lane, decides branches on lane 0 of the
 * first operand and registers everything for the result stage. A thread
 * under rollback is dropped at this stage's input.
 */
`timescale 1ns/1ps

module single_cycle_execute(
	input logic clk,
	input logic reset,
	input logic id_valid,
	input vec_pkg::alu_op_t id_alu_op,
	input vec_pkg::branch_type_t id_branch_type,
	input logic id_is_branch,
	input logic id_is_vector,
	input logic id_has_dest,
	input vec_pkg::reg_idx_t id_dest,
	input vec_pkg::scalar_t id_immediate,
	input vec_pkg::scalar_t id_pc,
	input vec_pkg::thread_idx_t id_thread,
	input vec_pkg::vector_t id_operand1,
	input vec_pkg::vector_t id_operand2,
	input vec_pkg::mask_t id_mask,
	input logic rollback_en,
	input vec_pkg::thread_idx_t rollback_thread,
	output logic sx_valid,
	output vec_pkg::alu_op_t sx_alu_op,
	output logic sx_is_vector,
	output logic sx_has_dest,
	output vec_pkg::reg_idx_t sx_dest,
	output vec_pkg::thread_idx_t sx_thread,
	output vec_pkg::mask_t sx_mask,
	output vec_pkg::vector_t sx_result,
	output logic sx_branch_taken,
	output vec_pkg::scalar_t sx_branch_target
);
	vec_pkg::vector_t lane_results;
	vec_pkg::scalar_t branch_operand;
	vec_pkg::scalar_t branch_target;
	logic issue;
	logic condition;

	genvar lane;
	generate
		for (lane = 0; lane < vec_pkg::vector_lanes; lane++)
		begin : lanes
			lane_alu alu(
				.alu_op(id_alu_op),
				.operand1(id_operand1[lane * vec_pkg::scalar_width +: vec_pkg::scalar_width]),
				.operand2(id_operand2[lane * vec_pkg::scalar_width +: vec_pkg::scalar_width]),
				.lane_index(2'(lane)),
				.vector_operand1(id_operand1),
				.result(lane_results[lane * vec_pkg::scalar_width +: vec_pkg::scalar_width]));
		end
	endgenerate

	assign issue = id_valid && !(rollback_en && rollback_thread == id_thread);
	assign branch_operand = id_operand1[vec_pkg::scalar_width - 1:0];

	always_comb
	begin
		case (id_branch_type)
			vec_pkg::branch_all: condition = branch_operand[15:0] == 16'hffff;
			vec_pkg::branch_not_all: condition = branch_operand[15:0] == 16'h0000;
			vec_pkg::branch_zero: condition = branch_operand == 32'd0;
			vec_pkg::branch_not_zero: condition = branch_operand != 32'd0;
			vec_pkg::branch_always,
			vec_pkg::branch_call_offset,
			vec_pkg::branch_call_register: condition = 1'b1;
			default: condition = 1'b0;
		endcase
	end

	assign branch_target = id_branch_type == vec_pkg::branch_call_register
		? branch_operand : id_pc + id_immediate;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sx_valid <= 1'b0;
			sx_branch_taken <= 1'b0;
		end
		else
		begin
			sx_valid <= issue;
			sx_branch_taken <= issue && id_is_branch && condition;
		end
	end

	always_ff @(posedge clk)
	begin
		sx_alu_op <= id_alu_op;
		sx_is_vector <= id_is_vector;
		sx_has_dest <= id_has_dest;
		sx_dest <= id_dest;
		sx_thread <= id_thread;
		sx_mask <= id_mask;
		sx_result <= lane_results;
		sx_branch_target <= branch_target;
	end

	taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
		sx_branch_taken |-> sx_valid);
endmodule

// ==== hdl/result_stage.sv ====
/*
 * Retire stage. Forms the register write, packing vector compares into a
 * lane bitmask, and issues the one-cycle rollback for a taken branch.
 */
`timescale 1ns/1ps

module result_stage(
	input logic clk,
	input logic reset,
	input logic sx_valid,
	input vec_pkg::alu_op_t sx_alu_op,
	input logic sx_is_vector,
	input logic sx_has_dest,
	input vec_pkg::reg_idx_t sx_dest,
	input vec_pkg::thread_idx_t sx_thread,
	input vec_pkg::mask_t sx_mask,
	input vec_pkg::vector_t sx_result,
	input logic sx_branch_taken,
	input vec_pkg::scalar_t sx_branch_target,
	output logic rollback_en,
	output vec_pkg::thread_idx_t rollback_thread,
	output vec_pkg::scalar_t rollback_pc,
	output logic wr_en,
	output vec_pkg::thread_idx_t wr_thread,
	output vec_pkg::reg_idx_t wr_dest,
	output vec_pkg::mask_t wr_mask,
	output vec_pkg::vector_t wr_data
);
	logic is_compare;
	vec_pkg::mask_t compare_bits;
	vec_pkg::vector_t write_data;
	vec_pkg::mask_t write_mask;

	assign is_compare = sx_alu_op >= vec_pkg::op_equal && sx_alu_op <= vec_pkg::op_uilte;

	// Bit 0 of each lane, disabled lanes read as 0
	always_comb
	begin
		for (int lane = 0; lane < vec_pkg::vector_lanes; lane++)
			compare_bits[lane] = sx_result[lane * vec_pkg::scalar_width] & sx_mask[lane];
	end

	always_comb
	begin
		if (sx_is_vector && is_compare)
		begin
			write_data = vec_pkg::vector_t'(compare_bits);
			write_mask = vec_pkg::mask_t'(1);
		end
		else if (sx_is_vector)
		begin
			write_data = sx_result;
			write_mask = sx_mask;
		end
		else
		begin
			write_data = vec_pkg::vector_t'(sx_result[vec_pkg::scalar_width - 1:0]);
			write_mask = vec_pkg::mask_t'(1);
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_en <= 1'b0;
			rollback_en <= 1'b0;
		end
		else
		begin
			wr_en <= sx_valid && sx_has_dest;
			rollback_en <= sx_valid && sx_branch_taken;
		end
	end

	always_ff @(posedge clk)
	begin
		wr_thread <= sx_thread;
		wr_dest <= sx_dest;
		wr_mask <= write_mask;
		wr_data <= write_data;
		rollback_thread <= sx_thread;
		rollback_pc <= sx_branch_target;
	end

	// Only calls write while rolling back
	plain_branch_no_write: assert property (@(posedge clk) disable iff (reset)
		sx_valid && sx_branch_taken && !sx_has_dest |=> rollback_en && !wr_en);
endmodule

// ==== hdl/vector_pipe_top.sv ====
/*
 * Top of the three-stage pipeline slice: decode, execute, retire.
 * The rollback from the retire stage feeds back into decode and execute.
 */
`timescale 1ns/1ps

module vector_pipe_top(
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input vec_pkg::instruction_t instr,
	input vec_pkg::scalar_t instr_pc,
	input vec_pkg::thread_idx_t instr_thread,
	input vec_pkg::vector_t operand1,
	input vec_pkg::vector_t operand2,
	input vec_pkg::mask_t mask,
	output logic wr_en,
	output vec_pkg::thread_idx_t wr_thread,
	output vec_pkg::reg_idx_t wr_dest,
	output vec_pkg::mask_t wr_mask,
	output vec_pkg::vector_t wr_data,
	output logic rollback_en,
	output vec_pkg::thread_idx_t rollback_thread,
	output vec_pkg::scalar_t rollback_pc
);
	// Decode to execute
	logic id_valid;
	vec_pkg::alu_op_t id_alu_op;
	vec_pkg::branch_type_t id_branch_type;
	logic id_is_branch;
	logic id_is_vector;
	logic id_has_dest;
	vec_pkg::reg_idx_t id_dest;
	vec_pkg::scalar_t id_immediate;
	vec_pkg::scalar_t id_pc;
	vec_pkg::thread_idx_t id_thread;
	vec_pkg::vector_t id_operand1;
	vec_pkg::vector_t id_operand2;
	vec_pkg::mask_t id_mask;

	// Execute to retire
	logic sx_valid;
	vec_pkg::alu_op_t sx_alu_op;
	logic sx_is_vector;
	logic sx_has_dest;
	vec_pkg::reg_idx_t sx_dest;
	vec_pkg::thread_idx_t sx_thread;
	vec_pkg::mask_t sx_mask;
	vec_pkg::vector_t sx_result;
	logic sx_branch_taken;
	vec_pkg::scalar_t sx_branch_target;

	// Port names match the stage signals, so connect by name
	instruction_decoder decode(.*);
	single_cycle_execute execute(.*);
	result_stage retire(.*);
endmodule

// ==== bench/vec_model.svh ====
/*
 * Reference model of the pipeline slice, included into the testbench module.
 * Covers lane operations, reciprocal table, branch decisions, write packing
 * and the squash rule.
 */
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

function automatic logic [5:0] recip_entry(input logic [5:0] index);
	int quotient;
	if (index == 6'd0)
		return 6'd0;
	quotient = 8192 / (64 + index);
	return 6'(quotient - 64);
endfunction

function automatic vec_pkg::scalar_t recip_estimate(input vec_pkg::scalar_t x);
	logic [7:0] exponent;
	exponent = x[30:23];
	if (exponent == 8'd0)
		return {x[31], 8'hff, 23'd0};
	if (exponent == 8'hff)
	begin
		if (x[22:0] != 23'd0)
			return {1'b0, 8'hff, 23'h7fffff};
		return {x[31], 31'd0};
	end
	// Exponent gains one when the table index is zero
	exponent = 8'(253 - exponent + (x[22:17] == 6'd0 ? 1 : 0));
	return {x[31], exponent, recip_entry(x[22:17]), 17'd0};
endfunction

function automatic vec_pkg::scalar_t leading_zeros(input vec_pkg::scalar_t x);
	int n;
	n = 0;
	while (n < 32 && !x[31 - n])
		n++;
	return n;
endfunction

function automatic vec_pkg::scalar_t trailing_zeros(input vec_pkg::scalar_t x);
	int n;
	n = 0;
	while (n < 32 && !x[n])
		n++;
	return n;
endfunction

function automatic logic is_compare(input vec_pkg::alu_op_t op);
	case (op)
		vec_pkg::op_equal, vec_pkg::op_nequal,
		vec_pkg::op_sigtr, vec_pkg::op_sigte, vec_pkg::op_silt, vec_pkg::op_silte,
		vec_pkg::op_uigtr, vec_pkg::op_uigte, vec_pkg::op_uilt, vec_pkg::op_uilte:
			return 1'b1;
		default:
			return 1'b0;
	endcase
endfunction

function automatic vec_pkg::scalar_t lane_result(input vec_pkg::alu_op_t op,
	input vec_pkg::scalar_t a, input vec_pkg::scalar_t b, input vec_pkg::vector_t v);
	vec_pkg::scalar_t r;
	r = '0;
	case (op)
		vec_pkg::op_asr:
			if (b >= 32)
				r = {32{a[31]}};
			else
				r = $signed(a) >>> b[4:0];
		vec_pkg::op_lsr: r = b >= 32 ? 32'd0 : a >> b[4:0];
		vec_pkg::op_lsl: r = b >= 32 ? 32'd0 : a << b[4:0];
		vec_pkg::op_copy: r = b;
		vec_pkg::op_or: r = a | b;
		vec_pkg::op_and: r = a & b;
		vec_pkg::op_xor: r = a ^ b;
		vec_pkg::op_iadd: r = a + b;
		vec_pkg::op_isub: r = a - b;
		vec_pkg::op_uminus: r = 32'd0 - b;
		vec_pkg::op_clz: r = leading_zeros(b);
		vec_pkg::op_ctz: r = trailing_zeros(b);
		vec_pkg::op_equal: r = a == b;
		vec_pkg::op_nequal: r = a != b;
		vec_pkg::op_sigtr: r = $signed(a) > $signed(b);
		vec_pkg::op_sigte: r = $signed(a) >= $signed(b);
		vec_pkg::op_silt: r = $signed(a) < $signed(b);
		vec_pkg::op_silte: r = $signed(a) <= $signed(b);
		vec_pkg::op_uigtr: r = a > b;
		vec_pkg::op_uigte: r = a >= b;
		vec_pkg::op_uilt: r = a < b;
		vec_pkg::op_uilte: r = a <= b;
		vec_pkg::op_sext8: r = {{24{b[7]}}, b[7:0]};
		vec_pkg::op_sext16: r = {{16{b[15]}}, b[15:0]};
		// Index 0 names the highest lane
		vec_pkg::op_getlane, vec_pkg::op_shuffle: r = v[(3 - b[1:0]) * 32 +: 32];
		vec_pkg::op_recip: r = recip_estimate(b);
		default: r = '0;
	endcase
	return r;
endfunction

function automatic vec_pkg::vector_t vector_result(input vec_pkg::alu_op_t op,
	input vec_pkg::vector_t a, input vec_pkg::vector_t b);
	vec_pkg::vector_t r;
	for (int lane = 0; lane < vec_pkg::vector_lanes; lane++)
		r[lane * 32 +: 32] = lane_result(op, a[lane * 32 +: 32], b[lane * 32 +: 32], a);
	return r;
endfunction

function automatic void write_value(input vec_pkg::alu_op_t op, input logic is_vector,
	input vec_pkg::mask_t lane_mask, input vec_pkg::vector_t lanes,
	output vec_pkg::vector_t data, output vec_pkg::mask_t data_mask);
	vec_pkg::mask_t bits;
	for (int lane = 0; lane < vec_pkg::vector_lanes; lane++)
		bits[lane] = lanes[lane * 32] & lane_mask[lane];
	if (is_vector && is_compare(op))
	begin
		data = vec_pkg::vector_t'(bits);
		data_mask = 4'd1;
	end
	else if (is_vector)
	begin
		data = lanes;
		data_mask = lane_mask;
	end
	else
	begin
		data = vec_pkg::vector_t'(lanes[31:0]);
		data_mask = 4'd1;
	end
endfunction

function automatic logic branch_taken(input vec_pkg::branch_type_t kind,
	input vec_pkg::scalar_t x);
	case (kind)
		vec_pkg::branch_all: return x[15:0] == 16'hffff;
		vec_pkg::branch_not_all: return x[15:0] == 16'h0000;
		vec_pkg::branch_zero: return x == 32'd0;
		vec_pkg::branch_not_zero: return x != 32'd0;
		vec_pkg::branch_always, vec_pkg::branch_call_offset,
		vec_pkg::branch_call_register: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic vec_pkg::scalar_t branch_target(input vec_pkg::branch_type_t kind,
	input vec_pkg::scalar_t pc, input logic [15:0] offset, input vec_pkg::scalar_t x);
	if (kind == vec_pkg::branch_call_register)
		return x;
	return pc + {{16{offset[15]}}, offset};
endfunction

// A stage drops its input when the same thread is rolling back
function automatic logic squashed(input logic rollback, input vec_pkg::thread_idx_t rb_thread,
	input vec_pkg::thread_idx_t thread);
	return rollback && rb_thread == thread;
endfunction

`endif

// ==== bench/vec_tb.sv ====
/*
 * Testbench for the vector pipeline slice. Random instructions from an
 * xorshift generator go through the DUT and every cycle the outputs are
 * compared with a three-slot model of the pipeline.
 */
`timescale 1ns/1ps

module vec_tb;
	`include "vec_model.svh"

	localparam int test_cycles = 3000;
	localparam int timeout_cycles = 4000;

	typedef struct packed {
		logic valid;
		vec_pkg::instruction_t instr;
		vec_pkg::scalar_t pc;
		vec_pkg::thread_idx_t thread;
		vec_pkg::vector_t op1;
		vec_pkg::vector_t op2;
		vec_pkg::mask_t mask;
	} slot_t;

	logic clk;
	logic reset;
	logic instr_valid;
	vec_pkg::instruction_t instr;
	vec_pkg::scalar_t instr_pc;
	vec_pkg::thread_idx_t instr_thread;
	vec_pkg::vector_t operand1;
	vec_pkg::vector_t operand2;
	vec_pkg::mask_t mask;
	logic wr_en;
	vec_pkg::thread_idx_t wr_thread;
	vec_pkg::reg_idx_t wr_dest;
	vec_pkg::mask_t wr_mask;
	vec_pkg::vector_t wr_data;
	logic rollback_en;
	vec_pkg::thread_idx_t rollback_thread;
	vec_pkg::scalar_t rollback_pc;

	// Slot 0 is in decode, 1 in execute, 2 at the outputs
	slot_t flight[$];
	logic [31:0] rng_state;
	int write_count;
	int rollback_count;
	int squash_count;

	vector_pipe_top uut(.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Biased lane values so branch conditions and zero inputs show up
	function automatic vec_pkg::scalar_t shaped_operand1();
		logic [31:0] r;
		r = next_random();
		case (next_random() % 6)
			0: return 32'd0;
			1: return {r[31:16], 16'hffff};
			2: return {r[31:16], 16'h0000};
			3: return r | 32'h8000_0000;
			default: return r;
		endcase
	endfunction

	// Shift amounts near 32 and float classes for the reciprocal
	function automatic vec_pkg::scalar_t shaped_operand2();
		logic [31:0] r;
		r = next_random();
		case (next_random() % 8)
			0: return 32'd0;
			1: return r % 64;
			2: return {r[31], 8'h00, r[4] ? r[22:0] : 23'd0};
			3: return {r[31], 8'hff, r[4] ? r[22:0] : 23'd0};
			4: return {r[31:23], 6'd0, r[16:0]};
			5: return {32{r[0]}};
			default: return r;
		endcase
	endfunction

	task automatic drive_idle();
		instr_valid = 1'b0;
		instr = '0;
		instr_pc = '0;
		instr_thread = '0;
		operand1 = '0;
		operand2 = '0;
		mask = '0;
	endtask

	task automatic drive_random();
		vec_pkg::instruction_t word;
		word = next_random();
		word[vec_pkg::is_branch_bit] = next_random() % 5 == 0;
		instr_valid = next_random() % 8 != 0;
		instr = word;
		instr_pc = next_random();
		instr_thread = next_random();
		mask = next_random();
		for (int lane = 0; lane < vec_pkg::vector_lanes; lane++)
		begin
			operand1[lane * 32 +: 32] = shaped_operand1();
			operand2[lane * 32 +: 32] = shaped_operand2();
		end
	endtask

	task automatic report_failure();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		assert (got === expected)
		else
		begin
			$display("Fail %s: got %h, expected %h", name, got, expected);
			report_failure();
		end
	endtask

	// Shift the model by one edge, using the inputs the DUT just sampled
	task automatic advance_model();
		slot_t retired;
		slot_t moving;
		slot_t incoming;
		logic rollback;
		retired = flight[2];
		moving = flight[0];
		rollback = retired.valid && retired.instr[vec_pkg::is_branch_bit]
			&& branch_taken(retired.instr[26:24], retired.op1[31:0]);
		incoming.valid = instr_valid;
		incoming.instr = instr;
		incoming.pc = instr_pc;
		incoming.thread = instr_thread;
		incoming.op1 = operand1;
		incoming.op2 = operand2;
		incoming.mask = mask;
		if (moving.valid && squashed(rollback, retired.thread, moving.thread))
		begin
			moving.valid = 1'b0;
			squash_count++;
		end
		if (incoming.valid && squashed(rollback, retired.thread, incoming.thread))
		begin
			incoming.valid = 1'b0;
			squash_count++;
		end
		void'(flight.pop_back());
		flight[0] = moving;
		flight.push_front(incoming);
	endtask

	task automatic check_outputs();
		slot_t s;
		logic exp_wr;
		logic exp_rb;
		vec_pkg::vector_t exp_data;
		vec_pkg::mask_t exp_mask;
		s = flight[2];
		exp_wr = s.valid && s.instr[vec_pkg::has_dest_bit];
		exp_rb = s.valid && s.instr[vec_pkg::is_branch_bit]
			&& branch_taken(s.instr[26:24], s.op1[31:0]);
		check_value("wr_en", wr_en, exp_wr);
		check_value("rollback_en", rollback_en, exp_rb);
		if (exp_wr)
		begin
			write_value(s.instr[31:27], s.instr[vec_pkg::is_vector_bit], s.mask,
				vector_result(s.instr[31:27], s.op1, s.op2), exp_data, exp_mask);
			check_value("wr_thread", wr_thread, s.thread);
			check_value("wr_dest", wr_dest, s.instr[20:16]);
			check_value("wr_mask", wr_mask, exp_mask);
			check_value("wr_data", wr_data, exp_data);
			write_count++;
		end
		if (exp_rb)
		begin
			check_value("rollback_thread", rollback_thread, s.thread);
			check_value("rollback_pc", rollback_pc,
				branch_target(s.instr[26:24], s.pc, s.instr[15:0], s.op1[31:0]));
			rollback_count++;
		end
	endtask

	initial
	begin : watchdog
		int waited;
		for (waited = 0; waited < timeout_cycles; waited++)
			@(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		report_failure();
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		rng_state = 32'h2786_617e;
		write_count = 0;
		rollback_count = 0;
		squash_count = 0;
		drive_idle();
		repeat (3)
			flight.push_back('0);
		repeat (4)
			@(posedge clk);
		#1 reset = 1'b0;

		// Idle at both ends so outputs are seen low after reset and the pipe drains
		for (int cycle = 0; cycle < test_cycles + 3; cycle++)
		begin
			@(posedge clk);
			advance_model();
			#1;
			check_outputs();
			if (cycle < 3 || cycle >= test_cycles)
				drive_idle();
			else
				drive_random();
		end

		assert (write_count > 0 && rollback_count > 0 && squash_count > 0)
		else
		begin
			$display("Stimulus never produced a write, a rollback and a squash");
			report_failure();
		end
		$display("Writes %0d, rollbacks %0d, squashed %0d",
			write_count, rollback_count, squash_count);
		$display("ALL TESTS PASSED");
		$finish;
	end
endmodule

// ==== project.f ====
+incdir+bench
hdl/vec_pkg.sv
hdl/reciprocal_rom.sv
hdl/lane_alu.sv
hdl/instruction_decoder.sv
hdl/single_cycle_execute.sv
hdl/result_stage.sv
hdl/vector_pipe_top.sv
bench/vec_tb.sv

// ==== Bender.yml ====
package:
  name: vector_pipe

sources:
  - files:
      - hdl/vec_pkg.sv
      - hdl/reciprocal_rom.sv
      - hdl/lane_alu.sv
      - hdl/instruction_decoder.sv
      - hdl/single_cycle_execute.sv
      - hdl/result_stage.sv
      - hdl/vector_pipe_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/vec_tb.sv
